/* dv/mapper_checker.sv */
/*
 * mapper read protocol checker
 * concurrent assertions bound into the bus control block
 */

`timescale 1ns/1ps

module mapper_checker (
	input logic                 clk,
	input logic                 n_reset,
	input mapper_pkg::bus_req_t bus_req,
	input mapper_pkg::ram_req_t ram_req,
	input logic                 bus_read_ready
);

	// failed assertions, read by the testbench at the end
	int unsigned assert_errors = 0;

	// memory read strobe on the slot bus
	logic mem_read;

	assign mem_read = bus_req.memory & bus_req.read;

	// ready is a single-cycle pulse
	ready_single: assert property (@(posedge clk) disable iff (!n_reset)
		bus_read_ready |=> !bus_read_ready)
	else begin
		$error("bus_read_ready was high in two consecutive cycles");
		assert_errors++;
	end

	// RAM never sees read and write together
	ram_exclusive: assert property (@(posedge clk) disable iff (!n_reset)
		!(ram_req.rd && ram_req.wr))
	else begin
		$error("RAM read and write strobes were high together");
		assert_errors++;
	end

	// fixed read latency from bus strobe to ready
	mem_read_ready: assert property (@(posedge clk) disable iff (!n_reset)
		mem_read |-> ##(mapper_pkg::RAM_READ_LATENCY) bus_read_ready)
	else begin
		$error("memory read was not answered after the fixed latency");
		assert_errors++;
	end

endmodule

bind mapper_ctrl mapper_checker u_checker (
	.clk            (clk),
	.n_reset        (n_reset),
	.bus_req        (bus_req),
	.ram_req        (ram_req),
	.bus_read_ready (bus_read_ready)
);

/* dv/mapper_tb.sv */
/*
 * memory mapper testbench
 * random I/O and memory traffic checked against a segment and RAM model
 */

`timescale 1ns/1ps

module mapper_tb;

	localparam int CLK_PERIOD      = 40;
	localparam int DRIVE_DELAY     = 2;
	localparam int RESET_CYCLES    = 10;
	localparam int READY_LIMIT     = 4;
	localparam logic [31:0] LFSR_SEED = 32'hea7af28f;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;
	localparam int N_IO = 32;
	localparam int N_BAD = 16;
	localparam int N_MEM = 256;
	localparam int N_ALIAS = 16;
	localparam int N_REWRITE = 8;
	localparam int TOTAL_OPS = 8 + 2 * N_IO + 2 * N_BAD + 4 + N_MEM + 4 * N_ALIAS + 8 * N_REWRITE;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 10 * TOTAL_OPS;

	logic                 clk;
	logic                 n_reset;
	mapper_pkg::bus_req_t bus_req;
	logic                 bus_read_ready;
	logic [7:0]           bus_read_data;

	logic [31:0] lfsr_q;
	// four segment bytes and the RAM bytes written so far
	logic [7:0]  seg_model [4];
	logic [7:0]  ram_model [int unsigned];
	logic [15:0] written_q [$];
	int          data_errors;
	int          timing_errors;
	int          protocol_errors;

	mapper_top DUT (
		.clk            (clk),
		.n_reset        (n_reset),
		.bus_req        (bus_req),
		.bus_read_ready (bus_read_ready),
		.bus_read_data  (bus_read_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// --------------------------------------------------
	// random numbers and model
	// --------------------------------------------------

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ LFSR_TAPS;
		end
		return s >> 1;
	endfunction

	// one LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_q[0]};
			lfsr_q = lfsr_step(lfsr_q);
		end
		return v;
	endfunction

	// low segment bits of the page register, then the page offset
	function automatic int unsigned ram_index(input logic [15:0] address);
		logic [7:0] seg;
		seg = seg_model[address[15:14]];
		return {seg[mapper_pkg::SEG_BITS-1:0], address[mapper_pkg::PAGE_BITS-1:0]};
	endfunction

	// port of a segment register, upper address byte is random
	function automatic logic [15:0] seg_port(input mapper_pkg::page_t page);
		logic [7:0] hi;
		hi = 8'(rand_bits(8));
		return {hi, mapper_pkg::SEG_PORT_BASE + 8'(page)};
	endfunction

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------

	task automatic check_data(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("mismatch %s: expected %02h, actual %02h", name, exp, act);
			data_errors++;
		end
	endtask

	task automatic check_ready_timing(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("mismatch %s: expected ready after %0d cycles, actual %0d", name, exp, act);
			timing_errors++;
		end
	endtask

	// --------------------------------------------------
	// bus driving
	// --------------------------------------------------

	task automatic drive_req(input mapper_pkg::bus_req_t req);
		@(posedge clk);
		#DRIVE_DELAY;
		bus_req = req;
	endtask

	// one-cycle write strobe, the next request replaces it
	task automatic bus_write(input logic io, input logic [15:0] address, input logic [7:0] data);
		mapper_pkg::bus_req_t req;
		logic [7:0] offset;
		req = '0;
		req.address = address;
		req.wdata = data;
		req.write = 1'b1;
		req.io = io;
		req.memory = !io;
		drive_req(req);
		offset = address[7:0] - mapper_pkg::SEG_PORT_BASE;
		if (!io) begin
			ram_model[ram_index(address)] = data;
		end else if (offset < 8'd4) begin
			seg_model[offset[1:0]] = data;
		end
	endtask

	// read strobe, then wait for ready; exp_cycles of zero means no ready
	task automatic check_read(input string name, input logic io, input logic [15:0] address,
			input logic [7:0] exp_data, input int exp_cycles);
		mapper_pkg::bus_req_t req;
		logic       got;
		logic [7:0] data;
		int         cycles;
		req = '0;
		req.address = address;
		req.read = 1'b1;
		req.io = io;
		req.memory = !io;
		got = 1'b0;
		data = '0;
		cycles = 1;
		drive_req(req);
		drive_req('0);
		// sample in mid cycle where outputs are settled
		while (!got && cycles <= READY_LIMIT) begin
			@(negedge clk);
			if (bus_read_ready) begin
				got = 1'b1;
				data = bus_read_data;
			end else begin
				@(posedge clk);
				cycles++;
			end
		end
		if (exp_cycles == 0) begin
			if (got) begin
				$display("error %s: read ready was given for port %02h", name, address[7:0]);
				protocol_errors++;
			end
		end else if (!got) begin
			$display("error %s: no read ready within %0d cycles", name, READY_LIMIT);
			protocol_errors++;
		end else begin
			check_ready_timing(name, exp_cycles, cycles);
			check_data(name, exp_data, data);
		end
	endtask

	// --------------------------------------------------
	// tests
	// --------------------------------------------------

	task automatic reset_values();
		for (int p = 0; p < 4; p++) begin
			check_read("reset_value", 1'b1, seg_port(mapper_pkg::page_t'(p)), 8'h00, 1);
		end
	endtask

	task automatic segment_io();
		mapper_pkg::page_t page;
		logic [7:0]        port;
		for (int i = 0; i < N_IO; i++) begin
			page = mapper_pkg::page_t'(rand_bits(2));
			bus_write(1'b1, seg_port(page), 8'(rand_bits(8)));
			check_read("segment_readback", 1'b1, seg_port(page), seg_model[page], 1);
		end
		// ports outside FC..FF, writes there must leave the registers alone
		for (int i = 0; i < N_BAD; i++) begin
			port = 8'(rand_bits(8));
			if (port >= mapper_pkg::SEG_PORT_BASE) begin
				port = port - 8'h10;
			end
			if (rand_bits(1) == 1) begin
				bus_write(1'b1, {8'h00, port}, 8'(rand_bits(8)));
			end
			check_read("unmapped_port", 1'b1, {8'h00, port}, 8'h00, 0);
		end
		for (int p = 0; p < 4; p++) begin
			check_read("segment_kept", 1'b1, seg_port(mapper_pkg::page_t'(p)), seg_model[p], 1);
		end
	endtask

	task automatic memory_random();
		logic [15:0] address;
		for (int p = 0; p < 4; p++) begin
			bus_write(1'b1, seg_port(mapper_pkg::page_t'(p)), 8'(rand_bits(8)));
		end
		written_q.delete();
		for (int i = 0; i < N_MEM; i++) begin
			if (written_q.size() == 0 || rand_bits(1) == 1) begin
				address = 16'(rand_bits(16));
				bus_write(1'b0, address, 8'(rand_bits(8)));
				written_q.push_back(address);
			end else begin
				address = written_q[rand_bits(16) % written_q.size()];
				check_read("memory_random", 1'b0, address, ram_model[ram_index(address)],
					mapper_pkg::RAM_READ_LATENCY);
			end
		end
	endtask

	// second page gets the same segment or one that differs above SEG_BITS
	task automatic page_alias();
		mapper_pkg::page_t page_a;
		mapper_pkg::page_t page_b;
		logic [7:0]        seg_a;
		logic [2:0]        hi_flip;
		logic [13:0]       offset;
		logic [7:0]        data;
		for (int i = 0; i < N_ALIAS; i++) begin
			page_a = mapper_pkg::page_t'(rand_bits(2));
			page_b = page_a + 2'd1;
			seg_a = 8'(rand_bits(8));
			hi_flip = (i % 2 == 0) ? 3'b000 : (3'(rand_bits(3)) | 3'b001);
			offset = 14'(rand_bits(14));
			data = 8'(rand_bits(8));
			bus_write(1'b1, seg_port(page_a), seg_a);
			bus_write(1'b1, seg_port(page_b), {seg_a[7:5] ^ hi_flip, seg_a[4:0]});
			bus_write(1'b0, {page_a, offset}, data);
			check_read("page_alias", 1'b0, {page_b, offset}, data, mapper_pkg::RAM_READ_LATENCY);
		end
	endtask

	// each register write is followed directly by the access it steers
	task automatic segment_rewrite();
		mapper_pkg::page_t page;
		logic [7:0]        seg_a;
		logic [7:0]        seg_b;
		logic [15:0]       address;
		logic [7:0]        data;
		for (int i = 0; i < N_REWRITE; i++) begin
			page = mapper_pkg::page_t'(rand_bits(2));
			seg_a = 8'(rand_bits(8));
			seg_b = seg_a ^ {3'b000, 5'(rand_bits(5)) | 5'd1};
			address = {page, 14'(rand_bits(14))};
			data = 8'(rand_bits(8));
			bus_write(1'b1, seg_port(page), seg_b);
			bus_write(1'b0, address, data);
			bus_write(1'b1, seg_port(page), seg_a);
			bus_write(1'b0, address, ~data);
			bus_write(1'b1, seg_port(page), seg_b);
			check_read("segment_rewrite", 1'b0, address, ram_model[ram_index(address)],
				mapper_pkg::RAM_READ_LATENCY);
			bus_write(1'b1, seg_port(page), seg_a);
			check_read("segment_rewrite", 1'b0, address, ram_model[ram_index(address)],
				mapper_pkg::RAM_READ_LATENCY);
		end
	endtask

	// --------------------------------------------------
	// sequence and watchdog
	// --------------------------------------------------

	initial begin
		int assert_total;
		clk = 1'b0;
		n_reset = 1'b0;
		bus_req = '0;
		lfsr_q = LFSR_SEED;
		data_errors = 0;
		timing_errors = 0;
		protocol_errors = 0;
		for (int p = 0; p < 4; p++) begin
			seg_model[p] = 8'h00;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		n_reset = 1'b1;
		reset_values();
		segment_io();
		memory_random();
		page_alias();
		segment_rewrite();
		drive_req('0);
		repeat (4) @(posedge clk);
		assert_total = DUT.u_ctrl.u_checker.assert_errors;
		$display("errors: data %0d, timing %0d, protocol %0d, assertion %0d",
			data_errors, timing_errors, protocol_errors, assert_total);
		if (data_errors + timing_errors + protocol_errors + assert_total == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// run length bound, ten cycles per planned operation
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("error: timeout, tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Finished with errors");
		$finish;
	end

endmodule

/* src/mapper_ctrl.sv */
/*
 * mapper bus control
 * decodes slot bus cycles into segment register and RAM accesses,
 * tracks pending memory reads and returns read data to the bus
 */

`timescale 1ns/1ps

module mapper_ctrl (
	input  logic                                clk,
	input  logic                                n_reset,
	// slot bus
	input  mapper_pkg::bus_req_t                bus_req,
	// segment registers
	output logic                                seg_write,
	output mapper_pkg::page_t                   seg_page,
	output logic [7:0]                          seg_wdata,
	input  logic [7:0]                          seg_rdata,
	input  logic [mapper_pkg::RAM_ADDR_BITS-1:0] ram_address,
	// RAM array
	output mapper_pkg::ram_req_t                ram_req,
	input  mapper_pkg::ram_rsp_t                ram_rsp,
	// read return
	output logic                                bus_read_ready,
	output logic [7:0]                          bus_read_data
);

	// low address byte relative to segment port 0
	logic [7:0] port_offset;

	// I/O cycle lands on one of the four segment ports
	logic port_hit;

	// decoded strobes
	logic io_seg_read;
	logic mem_read;
	logic mem_write;

	// memory read waiting for the RAM
	logic rd_pending_q;

	// readback pair, valid one cycle after the I/O read
	logic       io_ready_q;
	logic [7:0] io_data_q;

	// RAM data accepted for the bus
	logic mem_ready;

	// --------------------------------------------------
	// cycle decode
	// --------------------------------------------------

	// offset wraps on 8 bits, so any port below the base misses too
	assign port_offset = bus_req.address[7:0] - mapper_pkg::SEG_PORT_BASE;
	assign port_hit    = (port_offset[7:2] == 6'd0);

	assign io_seg_read = bus_req.io & bus_req.read & port_hit;
	assign mem_read    = bus_req.memory & bus_req.read;
	assign mem_write   = bus_req.memory & bus_req.write;

	// segment register access, other ports are ignored
	assign seg_write = bus_req.io & bus_req.write & port_hit;
	assign seg_page  = mapper_pkg::page_t'(port_offset[1:0]);
	assign seg_wdata = bus_req.wdata;

	// --------------------------------------------------
	// RAM request
	// --------------------------------------------------

	// memory cycles pass straight through with the translated address
	always_comb begin
		ram_req.rd      = mem_read;
		ram_req.wr      = mem_write;
		ram_req.address = ram_address;
		ram_req.wdata   = bus_req.wdata;
	end

	// --------------------------------------------------
	// pending memory read
	// --------------------------------------------------

	// set in the request cycle, cleared by the response strobe
	// the bus master waits, so only one read is ever owed to the bus
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			rd_pending_q <= 1'b0;
		end else if (mem_read) begin
			rd_pending_q <= 1'b1;
		end else if (ram_rsp.rdata_en) begin
			rd_pending_q <= 1'b0;
		end
	end

	assign mem_ready = rd_pending_q & ram_rsp.rdata_en;

	// --------------------------------------------------
	// segment readback
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			io_ready_q <= 1'b0;
		end else begin
			io_ready_q <= io_seg_read;
		end
	end

	// data is only looked at while io_ready_q is high
	always_ff @(posedge clk) begin
		if (io_seg_read) begin
			io_data_q <= seg_rdata;
		end
	end

	// --------------------------------------------------
	// bus return
	// --------------------------------------------------

	assign bus_read_ready = mem_ready | io_ready_q;

	// zero whenever ready is low
	always_comb begin
		if (mem_ready) begin
			bus_read_data = ram_rsp.rdata;
		end else if (io_ready_q) begin
			bus_read_data = io_data_q;
		end else begin
			bus_read_data = 8'h00;
		end
	end

endmodule

/* src/mapper_pkg.sv */
/*
 * memory mapper shared definitions
 * bus, RAM request and RAM response layouts plus sizing constants
 */

package mapper_pkg;

	// --------------------------------------------------
	// sizing
	// --------------------------------------------------

	// offset bits inside one 16 KB page
	localparam int PAGE_BITS = 14;

	// segment bits that reach the RAM, higher bits wrap
	localparam int SEG_BITS = 5;

	// byte address width of the local RAM (512 KB)
	localparam int RAM_ADDR_BITS = SEG_BITS + PAGE_BITS;

	// I/O port of segment register 0, ports FC..FF map to 0..3
	localparam logic [7:0] SEG_PORT_BASE = 8'hFC;

	// cycles from a RAM read strobe to its rdata_en
	localparam int RAM_READ_LATENCY = 2;

	// --------------------------------------------------
	// types
	// --------------------------------------------------

	// page index, taken from bus address bits 15:14
	typedef logic [1:0] page_t;

	// one sample of the slot bus
	typedef struct packed {
		logic [15:0] address;
		logic [7:0]  wdata;
		logic        read;
		logic        write;
		logic        io;
		logic        memory;
	} bus_req_t;

	// request towards the RAM array
	typedef struct packed {
		logic                     rd;
		logic                     wr;
		logic [RAM_ADDR_BITS-1:0] address;
		logic [7:0]               wdata;
	} ram_req_t;

	// read return from the RAM array
	typedef struct packed {
		logic [7:0] rdata;
		logic       rdata_en;
	} ram_rsp_t;

endpackage

/* src/mapper_segments.sv */
/*
 * mapper segment registers
 * four 8-bit page registers with I/O write and readback,
 * and translation of the CPU address into a RAM byte address
 */

`timescale 1ns/1ps

module mapper_segments (
	input  logic                                clk,
	input  logic                                n_reset,
	// I/O side
	input  logic                                seg_write,
	input  mapper_pkg::page_t                   seg_page,
	input  logic [7:0]                          seg_wdata,
	output logic [7:0]                          seg_rdata,
	// memory side
	input  logic [15:0]                         bus_address,
	output logic [mapper_pkg::RAM_ADDR_BITS-1:0] ram_address
);

	// one byte per page, index is the page number
	logic [3:0][7:0] seg_q;

	// page hit by the current memory cycle
	mapper_pkg::page_t bus_page;

	// segment byte selected for that page
	logic [7:0] bus_seg;

	// --------------------------------------------------
	// register file
	// --------------------------------------------------

	// full 8 bits are kept even though only the low bits reach the RAM
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			seg_q <= '0;
		end else if (seg_write) begin
			seg_q[seg_page] <= seg_wdata;
		end
	end

	// readback of the register addressed by the I/O port
	assign seg_rdata = seg_q[seg_page];

	// --------------------------------------------------
	// address translation
	// --------------------------------------------------

	// top two CPU address bits pick the page
	assign bus_page = mapper_pkg::page_t'(bus_address[15:14]);

	always_comb begin
		bus_seg = seg_q[bus_page];
	end

	// segment number modulo 2**SEG_BITS, followed by the page offset
	// a write in the previous cycle is already visible here
	assign ram_address = {
		bus_seg[mapper_pkg::SEG_BITS-1:0],
		bus_address[mapper_pkg::PAGE_BITS-1:0]
	};

endmodule

/* src/mapper_top.sv */
/*
 * memory mapper top level
 * slot bus port with four 16 KB pages mapped into a local 512 KB RAM
 */

`timescale 1ns/1ps

module mapper_top (
	input  logic                 clk,
	input  logic                 n_reset,
	input  mapper_pkg::bus_req_t bus_req,
	output logic                 bus_read_ready,
	output logic [7:0]           bus_read_data
);

	// --------------------------------------------------
	// internal nets
	// --------------------------------------------------

	// segment register access
	logic              seg_write;
	mapper_pkg::page_t seg_page;
	logic [7:0]        seg_wdata;
	logic [7:0]        seg_rdata;

	// translated byte address
	logic [mapper_pkg::RAM_ADDR_BITS-1:0] ram_address;

	// RAM request and response
	mapper_pkg::ram_req_t ram_req;
	mapper_pkg::ram_rsp_t ram_rsp;

	// --------------------------------------------------
	// blocks
	// --------------------------------------------------

	// bus decode and read return
	mapper_ctrl u_ctrl (
		.clk            (clk),
		.n_reset        (n_reset),
		.bus_req        (bus_req),
		.seg_write      (seg_write),
		.seg_page       (seg_page),
		.seg_wdata      (seg_wdata),
		.seg_rdata      (seg_rdata),
		.ram_address    (ram_address),
		.ram_req        (ram_req),
		.ram_rsp        (ram_rsp),
		.bus_read_ready (bus_read_ready),
		.bus_read_data  (bus_read_data)
	);

	// page registers, translation uses the raw bus address
	mapper_segments u_segments (
		.clk         (clk),
		.n_reset     (n_reset),
		.seg_write   (seg_write),
		.seg_page    (seg_page),
		.seg_wdata   (seg_wdata),
		.seg_rdata   (seg_rdata),
		.bus_address (bus_req.address),
		.ram_address (ram_address)
	);

	// local RAM
	ram_array u_ram (
		.clk     (clk),
		.n_reset (n_reset),
		.ram_req (ram_req),
		.ram_rsp (ram_rsp)
	);

endmodule

/* src/ram_array.sv */
/*
 * mapper local RAM
 * synchronous byte array with a fixed-latency read pipeline
 */

`timescale 1ns/1ps

module ram_array (
	input  logic                 clk,
	input  logic                 n_reset,
	input  mapper_pkg::ram_req_t ram_req,
	output mapper_pkg::ram_rsp_t ram_rsp
);

	localparam int DEPTH = 2 ** mapper_pkg::RAM_ADDR_BITS;
	localparam int LAT   = mapper_pkg::RAM_READ_LATENCY;

	// storage, contents survive reset
	logic [7:0] mem [DEPTH];

	// read pipeline, stage 0 is loaded in the request cycle
	logic [LAT-1:0]      rd_valid_q;
	logic [LAT-1:0][7:0] rd_data_q;

	// --------------------------------------------------
	// write port
	// --------------------------------------------------

	// byte is stored at the end of the request cycle
	always_ff @(posedge clk) begin
		if (ram_req.wr) begin
			mem[ram_req.address] <= ram_req.wdata;
		end
	end

	// --------------------------------------------------
	// read pipeline
	// --------------------------------------------------

	// valid bits shift every cycle, a new read may enter each cycle
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			rd_valid_q <= '0;
		end else begin
			rd_valid_q <= {rd_valid_q[LAT-2:0], ram_req.rd};
		end
	end

	// data stages follow the valid bits without reset
	always_ff @(posedge clk) begin
		if (ram_req.rd) begin
			rd_data_q[0] <= mem[ram_req.address];
		end
		for (int i = 1; i < LAT; i++) begin
			rd_data_q[i] <= rd_data_q[i-1];
		end
	end

	// last stage drives the response
	always_comb begin
		ram_rsp.rdata    = rd_data_q[LAT-1];
		ram_rsp.rdata_en = rd_valid_q[LAT-1];
	end

endmodule

/* vlog.f */
src/mapper_pkg.sv
src/mapper_segments.sv
src/mapper_ctrl.sv
src/ram_array.sv
src/mapper_top.sv
dv/mapper_checker.sv
dv/mapper_tb.sv
